// ==== source/async_fifo_pkg.sv ====
package async_fifo_pkg;

        // ------------------------------
        // Read timing of the head word
        // ------------------------------

        // Mux reads the array directly, flop adds a RAM output register
        typedef enum logic {
                MODE_MUX,
                MODE_FLOP
        } fifo_mode_e;

        // ------------------------------
        // Status flags per domain
        // ------------------------------

        // Write side, valid on wr_clk
        typedef struct packed {
                logic full;
                logic almost_full;
        } wr_flags_t;

        // Read side, valid on rd_clk
        typedef struct packed {
                logic empty;
                logic almost_empty;
        } rd_flags_t;

endpackage

// ==== source/fifo_ptr_counter.sv ====
`timescale 1ns/10ps

module fifo_ptr_counter #(
        parameter int ADDR_WIDTH = 4
) (
        input  logic                  clk,
        input  logic                  rst_n,
        // Already qualified by full or empty
        input  logic                  inc,
        output logic [ADDR_WIDTH:0]   ptr_bin,
        output logic [ADDR_WIDTH:0]   ptr_next
);

        // ------------------------------
        // Look-ahead value
        // ------------------------------

        // Extra top bit counts laps around the array
        // Wraps on its own at 2**(ADDR_WIDTH+1)
        always_comb begin
                if (inc) begin
                        ptr_next = ptr_bin + 1'b1;
                end else begin
                        ptr_next = ptr_bin;
                end
        end

        // ------------------------------
        // Pointer register
        // ------------------------------

        // Loads every edge, holds when inc is low
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ptr_bin <= '0;
                end else begin
                        ptr_bin <= ptr_next;
                end
        end

endmodule

// ==== source/fifo_ptr_sync.sv ====
`timescale 1ns/10ps

module fifo_ptr_sync #(
        parameter int ADDR_WIDTH = 4
) (
        input  logic                  src_clk,
        input  logic                  src_rst_n,
        input  logic [ADDR_WIDTH:0]   src_ptr_bin,
        input  logic                  dst_clk,
        input  logic                  dst_rst_n,
        output logic [ADDR_WIDTH:0]   dst_ptr_bin
);

        // Gray copy launched from a flop in the source domain
        logic [ADDR_WIDTH:0] src_gray;
        // Two stage synchronizer in the destination domain
        logic [ADDR_WIDTH:0] sync_q1;
        logic [ADDR_WIDTH:0] sync_q2;

        // ------------------------------
        // Source side
        // ------------------------------

        // Only one bit changes per step, so a late sample is old or new, never mixed
        always_ff @(posedge src_clk or negedge src_rst_n) begin
                if (!src_rst_n) begin
                        src_gray <= '0;
                end else begin
                        src_gray <= src_ptr_bin ^ (src_ptr_bin >> 1);
                end
        end

        // ------------------------------
        // Destination side
        // ------------------------------

        // First stage may go metastable, second settles it
        always_ff @(posedge dst_clk or negedge dst_rst_n) begin
                if (!dst_rst_n) begin
                        sync_q1 <= '0;
                        sync_q2 <= '0;
                end else begin
                        sync_q1 <= src_gray;
                        sync_q2 <= sync_q1;
                end
        end

        // Gray to binary
        // Each bit is the XOR of itself and all higher Gray bits
        always_comb begin
                for (int i = 0; i <= ADDR_WIDTH; i++) begin
                        dst_ptr_bin[i] = ^(sync_q2 >> i);
                end
        end

endmodule

// ==== source/fifo_mem.sv ====
`timescale 1ns/10ps

module fifo_mem import async_fifo_pkg::*; #(
        parameter int         DATA_WIDTH = 8,
        parameter int         ADDR_WIDTH = 4,
        parameter fifo_mode_e MODE       = MODE_MUX
) (
        input  logic                    wr_clk,
        input  logic                    wr_en,
        input  logic [ADDR_WIDTH-1:0]   wr_addr,
        input  logic [DATA_WIDTH-1:0]   wr_data,
        input  logic                    rd_clk,
        // Head address in mux mode, next head address in flop mode
        input  logic [ADDR_WIDTH-1:0]   rd_addr,
        output logic [DATA_WIDTH-1:0]   rd_data
);

        localparam int DEPTH = 1 << ADDR_WIDTH;

        // Storage array
        logic [DATA_WIDTH-1:0] mem [DEPTH];

        // Write port on wr_clk
        always_ff @(posedge wr_clk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // ------------------------------
        // Read port
        // ------------------------------
        generate
                if (MODE == MODE_FLOP) begin : gen_flop
                        logic [DATA_WIDTH-1:0] rd_data_q;
                        // Follows the next head, so a pop and the new word land on one edge
                        always_ff @(posedge rd_clk) begin
                                rd_data_q <= mem[rd_addr];
                        end
                        assign rd_data = rd_data_q;
                end else begin : gen_mux
                        // Straight from the array
                        assign rd_data = mem[rd_addr];
                end
        endgenerate

endmodule

// ==== source/fifo_control.sv ====
`timescale 1ns/10ps

module fifo_control import async_fifo_pkg::*; #(
        parameter int         ADDR_WIDTH       = 4,
        parameter int         ALMOST_WR_MARGIN = 2,
        parameter int         ALMOST_RD_MARGIN = 2,
        parameter fifo_mode_e MODE             = MODE_MUX
) (
        input  logic                  wr_clk,
        input  logic                  wr_rst_n,
        input  logic                  rd_clk,
        input  logic                  rd_rst_n,
        // Look-ahead write pointer, wr_clk domain
        input  logic [ADDR_WIDTH:0]   wr_ptr_bin,
        // Read pointer after crossing, wr_clk domain
        input  logic [ADDR_WIDTH:0]   wdom_rd_ptr_bin,
        // Look-ahead read pointer, rd_clk domain
        input  logic [ADDR_WIDTH:0]   rd_ptr_bin,
        // Write pointer after crossing, rd_clk domain
        input  logic [ADDR_WIDTH:0]   rdom_wr_ptr_bin,
        output wr_flags_t             wr_flags,
        output rd_flags_t             rd_flags,
        output logic [ADDR_WIDTH:0]   count
);

        localparam int DEPTH = 1 << ADDR_WIDTH;
        localparam int AW    = ADDR_WIDTH;

        // Thresholds at pointer width so DEPTH itself fits
        localparam logic [AW:0] AF_LEVEL = (AW+1)'(DEPTH - ALMOST_WR_MARGIN);
        localparam logic [AW:0] AE_LEVEL = (AW+1)'(ALMOST_RD_MARGIN);

        // Write side terms
        logic [AW:0] wr_occ;
        logic        full_d;
        logic        almost_full_d;

        // Read side terms
        logic [AW:0] wr_ptr_for_empty;
        logic [AW:0] rd_occ;
        logic [AW:0] rd_occ_empty;
        logic        empty_d;
        logic        almost_empty_d;

        // ------------------------------
        // Write domain
        // ------------------------------

        // Lap bits differ and index bits match
        assign full_d = (wr_ptr_bin[AW] != wdom_rd_ptr_bin[AW]) &&
                        (wr_ptr_bin[AW-1:0] == wdom_rd_ptr_bin[AW-1:0]);

        // Extra bit makes modulo subtraction exact, 0 up to DEPTH
        assign wr_occ        = wr_ptr_bin - wdom_rd_ptr_bin;
        assign almost_full_d = (wr_occ >= AF_LEVEL);

        // Built from the next pointer, so valid at the edge of the push
        always_ff @(posedge wr_clk or negedge wr_rst_n) begin
                if (!wr_rst_n) begin
                        wr_flags <= '0;
                end else begin
                        wr_flags.full        <= full_d;
                        wr_flags.almost_full <= almost_full_d;
                end
        end

        // ------------------------------
        // Read domain
        // ------------------------------

        // Occupancy seen by the read side
        assign rd_occ = rdom_wr_ptr_bin - rd_ptr_bin;

        generate
                if (MODE == MODE_FLOP) begin : gen_flop
                        logic [AW:0] wr_ptr_dly;
                        logic [AW:0] count_q;
                        // Extra rd_clk of delay covers the RAM output register
                        always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                                if (!rd_rst_n) begin
                                        wr_ptr_dly <= '0;
                                        count_q    <= '0;
                                end else begin
                                        wr_ptr_dly <= rdom_wr_ptr_bin;
                                        count_q    <= rd_occ;
                                end
                        end
                        assign wr_ptr_for_empty = wr_ptr_dly;
                        assign count            = count_q;
                end else begin : gen_mux
                        // Head word readable as soon as the pointer arrives
                        assign wr_ptr_for_empty = rdom_wr_ptr_bin;
                        assign count            = rd_occ;
                end
        endgenerate

        // Equal pointers, lap bit included
        assign empty_d = (rd_ptr_bin == wr_ptr_for_empty);

        // Same pointer as empty, so empty always implies almost_empty
        assign rd_occ_empty   = wr_ptr_for_empty - rd_ptr_bin;
        assign almost_empty_d = (rd_occ_empty <= AE_LEVEL);

        // Empty out of reset
        always_ff @(posedge rd_clk or negedge rd_rst_n) begin
                if (!rd_rst_n) begin
                        rd_flags.empty        <= 1'b1;
                        rd_flags.almost_empty <= 1'b1;
                end else begin
                        rd_flags.empty        <= empty_d;
                        rd_flags.almost_empty <= almost_empty_d;
                end
        end

endmodule

// ==== source/async_fifo.sv ====
`timescale 1ns/10ps

module async_fifo import async_fifo_pkg::*; #(
        parameter int         DATA_WIDTH       = 8,
        parameter int         ADDR_WIDTH       = 4,
        parameter int         ALMOST_WR_MARGIN = 2,
        parameter int         ALMOST_RD_MARGIN = 2,
        parameter fifo_mode_e MODE             = MODE_MUX
) (
        // Write side
        input  logic                    wr_clk,
        input  logic                    wr_rst_n,
        input  logic                    push,
        input  logic [DATA_WIDTH-1:0]   wr_data,
        output wr_flags_t               wr_flags,
        // Read side
        input  logic                    rd_clk,
        input  logic                    rd_rst_n,
        input  logic                    pop,
        output logic [DATA_WIDTH-1:0]   rd_data,
        output rd_flags_t               rd_flags,
        output logic [ADDR_WIDTH:0]     count
);

        // Accepted strobes
        logic wr_inc;
        logic rd_inc;

        // Local pointers, registered and look-ahead
        logic [ADDR_WIDTH:0] wr_ptr_bin;
        logic [ADDR_WIDTH:0] wr_ptr_next;
        logic [ADDR_WIDTH:0] rd_ptr_bin;
        logic [ADDR_WIDTH:0] rd_ptr_next;

        // Pointers after crossing
        logic [ADDR_WIDTH:0] rdom_wr_ptr_bin;
        logic [ADDR_WIDTH:0] wdom_rd_ptr_bin;

        logic [ADDR_WIDTH-1:0] mem_rd_addr;

        // ------------------------------
        // Strobe gating
        // ------------------------------

        // Push while full and pop while empty are dropped here
        assign wr_inc = push & ~wr_flags.full;
        assign rd_inc = pop & ~rd_flags.empty;

        // Flop mode reads one address ahead into the output register
        assign mem_rd_addr = (MODE == MODE_FLOP) ? rd_ptr_next[ADDR_WIDTH-1:0]
                                                 : rd_ptr_bin[ADDR_WIDTH-1:0];

        // ------------------------------
        // Pointers and crossings
        // ------------------------------
        fifo_ptr_counter #(.ADDR_WIDTH(ADDR_WIDTH)) u_wr_ptr (
                .clk      (wr_clk),
                .rst_n    (wr_rst_n),
                .inc      (wr_inc),
                .ptr_bin  (wr_ptr_bin),
                .ptr_next (wr_ptr_next)
        );

        fifo_ptr_counter #(.ADDR_WIDTH(ADDR_WIDTH)) u_rd_ptr (
                .clk      (rd_clk),
                .rst_n    (rd_rst_n),
                .inc      (rd_inc),
                .ptr_bin  (rd_ptr_bin),
                .ptr_next (rd_ptr_next)
        );

        // Write pointer into rd_clk
        fifo_ptr_sync #(.ADDR_WIDTH(ADDR_WIDTH)) u_wr2rd (
                .src_clk     (wr_clk),
                .src_rst_n   (wr_rst_n),
                .src_ptr_bin (wr_ptr_bin),
                .dst_clk     (rd_clk),
                .dst_rst_n   (rd_rst_n),
                .dst_ptr_bin (rdom_wr_ptr_bin)
        );

        // Read pointer into wr_clk
        fifo_ptr_sync #(.ADDR_WIDTH(ADDR_WIDTH)) u_rd2wr (
                .src_clk     (rd_clk),
                .src_rst_n   (rd_rst_n),
                .src_ptr_bin (rd_ptr_bin),
                .dst_clk     (wr_clk),
                .dst_rst_n   (wr_rst_n),
                .dst_ptr_bin (wdom_rd_ptr_bin)
        );

        // ------------------------------
        // Storage and flags
        // ------------------------------
        fifo_mem #(
                .DATA_WIDTH (DATA_WIDTH),
                .ADDR_WIDTH (ADDR_WIDTH),
                .MODE       (MODE)
        ) u_mem (
                .wr_clk  (wr_clk),
                .wr_en   (wr_inc),
                .wr_addr (wr_ptr_bin[ADDR_WIDTH-1:0]),
                .wr_data (wr_data),
                .rd_clk  (rd_clk),
                .rd_addr (mem_rd_addr),
                .rd_data (rd_data)
        );

        // Flags use the look-ahead pointers of the local side
        fifo_control #(
                .ADDR_WIDTH       (ADDR_WIDTH),
                .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN),
                .ALMOST_RD_MARGIN (ALMOST_RD_MARGIN),
                .MODE             (MODE)
        ) u_ctrl (
                .wr_clk          (wr_clk),
                .wr_rst_n        (wr_rst_n),
                .rd_clk          (rd_clk),
                .rd_rst_n        (rd_rst_n),
                .wr_ptr_bin      (wr_ptr_next),
                .wdom_rd_ptr_bin (wdom_rd_ptr_bin),
                .rd_ptr_bin      (rd_ptr_next),
                .rdom_wr_ptr_bin (rdom_wr_ptr_bin),
                .wr_flags        (wr_flags),
                .rd_flags        (rd_flags),
                .count           (count)
        );

endmodule

// ==== tests/async_fifo_props.sv ====
`timescale 1ns/10ps

module async_fifo_props import async_fifo_pkg::*; #(
        parameter int ADDR_WIDTH = 4
) (
        input logic                  wr_clk,
        input logic                  wr_rst_n,
        input logic                  push,
        input wr_flags_t             wr_flags,
        input logic [ADDR_WIDTH:0]   wr_ptr_bin,
        input logic                  rd_clk,
        input logic                  rd_rst_n,
        input logic                  pop,
        input rd_flags_t             rd_flags,
        input logic [ADDR_WIDTH:0]   rd_ptr_bin
);

        // ------------------------------
        // Dropped strobes
        // ------------------------------

        // Push into a full FIFO leaves the write pointer alone
        push_while_full: assert property (
                @(posedge wr_clk) disable iff (!wr_rst_n)
                (push && wr_flags.full) |=> $stable(wr_ptr_bin)
        ) else $error("write pointer moved on a push while full");

        // Pop from an empty FIFO leaves the read pointer alone
        pop_while_empty: assert property (
                @(posedge rd_clk) disable iff (!rd_rst_n)
                (pop && rd_flags.empty) |=> $stable(rd_ptr_bin)
        ) else $error("read pointer moved on a pop while empty");

        // ------------------------------
        // Flag consistency
        // ------------------------------

        // Depth 16 is far too deep for both views to be stale at once
        full_and_empty: assert property (
                @(posedge rd_clk) disable iff (!wr_rst_n || !rd_rst_n)
                !(wr_flags.full && rd_flags.empty)
        ) else $error("full and empty were set together");

        full_gives_almost: assert property (
                @(posedge wr_clk) disable iff (!wr_rst_n)
                wr_flags.full |-> wr_flags.almost_full
        ) else $error("full was set without almost_full");

endmodule

// Attached to every async_fifo instance
bind async_fifo async_fifo_props #(.ADDR_WIDTH(ADDR_WIDTH)) u_props (
        .wr_clk     (wr_clk),
        .wr_rst_n   (wr_rst_n),
        .push       (push),
        .wr_flags   (wr_flags),
        .wr_ptr_bin (wr_ptr_bin),
        .rd_clk     (rd_clk),
        .rd_rst_n   (rd_rst_n),
        .pop        (pop),
        .rd_flags   (rd_flags),
        .rd_ptr_bin (rd_ptr_bin)
);

// ==== tests/async_fifo_tb.sv ====
`timescale 1ns/10ps

module async_fifo_tb import async_fifo_pkg::*; #(
        // 0 for mux read, 1 for flop read
        parameter int MODE = 0
);

        localparam int DATA_WIDTH = 8;
        localparam int ADDR_WIDTH = 4;
        localparam int DEPTH      = 1 << ADDR_WIDTH;
        // Margins of 2 on both sides
        localparam int AF_LEVEL   = DEPTH - 2;
        localparam int AE_LEVEL   = 2;
        localparam int WR_HALF    = 14;
        localparam int RD_HALF    = 20;
        localparam int WAIT_LIMIT = 64;
        localparam int RUN_LIMIT  = 5000;

        logic                  wr_clk = 1'b0;
        logic                  rd_clk = 1'b0;
        logic                  wr_rst_n;
        logic                  rd_rst_n;
        logic                  push;
        logic                  pop;
        logic [DATA_WIDTH-1:0] wr_data;
        logic [DATA_WIDTH-1:0] rd_data;
        wr_flags_t             wr_flags;
        rd_flags_t             rd_flags;
        logic [ADDR_WIDTH:0]   count;

        // Words accepted by the DUT, oldest first
        logic [DATA_WIDTH-1:0] model_q[$];
        // One LFSR per clock domain
        logic [15:0] wr_lfsr = 16'd28512;
        logic [15:0] rd_lfsr = 16'd28512;

        // 28 ns against 40 ns, so the edges drift
        always #(WR_HALF) wr_clk = ~wr_clk;
        always #(RD_HALF) rd_clk = ~rd_clk;

        async_fifo #(
                .DATA_WIDTH       (DATA_WIDTH),
                .ADDR_WIDTH       (ADDR_WIDTH),
                .ALMOST_WR_MARGIN (2),
                .ALMOST_RD_MARGIN (2),
                .MODE             (fifo_mode_e'(MODE))
        ) DUT (
                .wr_clk   (wr_clk),
                .wr_rst_n (wr_rst_n),
                .push     (push),
                .wr_data  (wr_data),
                .wr_flags (wr_flags),
                .rd_clk   (rd_clk),
                .rd_rst_n (rd_rst_n),
                .pop      (pop),
                .rd_data  (rd_data),
                .rd_flags (rd_flags),
                .count    (count)
        );

        // ------------------------------
        // Failure exits
        // ------------------------------
        task automatic abort_run();
                $display("Test FAILED");
                $fatal(1);
        endtask

        task automatic show_mismatch(input string msg);
                $display("** Error at %0d ns: %s", $time, msg);
                abort_run();
        endtask

        task automatic waited_too_long(input string msg);
                $display("Timeout, %s", msg);
                abort_run();
        endtask

        // ------------------------------
        // Random bits
        // ------------------------------

        // Fibonacci, taps 16 14 13 11
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        // One step per bit
        task automatic take_bits(inout logic [15:0] state, input int n,
                                 output logic [7:0] bits);
                bits = '0;
                for (int i = 0; i < n; i++) begin
                        state = lfsr_next(state);
                        bits  = {bits[6:0], state[0]};
                end
        endtask

        // ------------------------------
        // One cycle per side
        // ------------------------------

        // Decides the push for the next wr_clk edge
        task automatic wr_cycle(input logic want);
                logic [7:0] d;
                @(posedge wr_clk);
                #2;
                take_bits(wr_lfsr, DATA_WIDTH, d);
                push    = want;
                wr_data = d;
                if (want && !wr_flags.full) begin
                        model_q.push_back(d);
                end
        endtask

        // Head word is checked when the pop is sure to be taken
        task automatic rd_cycle(input logic want, output logic took);
                @(posedge rd_clk);
                #2;
                pop  = want;
                took = want && !rd_flags.empty;
                if (took) begin
                        assert (model_q.size() != 0)
                                else show_mismatch("pop accepted with no word pushed");
                        assert (rd_data === model_q[0])
                                else show_mismatch($sformatf("rd_data %h, expected %h",
                                                             rd_data, model_q[0]));
                        void'(model_q.pop_front());
                end
        endtask

        // ------------------------------
        // Traffic
        // ------------------------------

        // Density in quarters
        task automatic random_writes(input int cycles, input int density);
                logic [7:0] r;
                for (int i = 0; i < cycles; i++) begin
                        take_bits(wr_lfsr, 2, r);
                        wr_cycle(r[1:0] < density);
                end
                wr_cycle(1'b0);
        endtask

        task automatic random_reads(input int cycles, input int density);
                logic [7:0] r;
                logic       took;
                for (int i = 0; i < cycles; i++) begin
                        take_bits(rd_lfsr, 2, r);
                        rd_cycle(r[1:0] < density, took);
                end
                rd_cycle(1'b0, took);
        endtask

        task automatic push_words(input int n);
                int target;
                int cycles;
                target = model_q.size() + n;
                cycles = 0;
                while (model_q.size() < target) begin
                        wr_cycle(1'b1);
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                waited_too_long("pushes were not accepted");
                        end
                end
                wr_cycle(1'b0);
        endtask

        task automatic pop_words(input int n);
                int   popped;
                int   cycles;
                logic took;
                popped = 0;
                cycles = 0;
                while (popped < n) begin
                        rd_cycle(1'b1, took);
                        popped += int'(took);
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                waited_too_long("pops were not accepted");
                        end
                end
                rd_cycle(1'b0, took);
        endtask

        // Pushes every cycle with no pops, full must track the sixteenth word
        task automatic fill_to_full();
                int n;
                for (int i = 0; i < DEPTH + 4; i++) begin
                        n = model_q.size();
                        wr_cycle(1'b1);
                        assert (wr_flags.full == (n == DEPTH))
                                else show_mismatch($sformatf("full %b with %0d words",
                                                             wr_flags.full, n));
                        assert (wr_flags.almost_full == (n >= AF_LEVEL))
                                else show_mismatch("almost_full wrong while filling");
                end
                wr_cycle(1'b0);
        endtask

        // Pops until empty is seen, then pops into the empty FIFO
        task automatic drain_until_empty();
                int   expected;
                int   popped;
                int   cycles;
                logic took;
                expected = model_q.size();
                popped   = 0;
                cycles   = 0;
                took     = 1'b1;
                while (took) begin
                        rd_cycle(1'b1, took);
                        popped += int'(took);
                        cycles++;
                        if (cycles > WAIT_LIMIT) begin
                                waited_too_long("empty did not rise while draining");
                        end
                end
                assert (popped == expected && model_q.size() == 0)
                        else show_mismatch($sformatf("drained %0d words, expected %0d",
                                                     popped, expected));
                for (int i = 0; i < 4; i++) begin
                        rd_cycle(1'b1, took);
                        assert (rd_flags.empty && count == 0)
                                else show_mismatch("pop while empty changed the FIFO");
                end
                rd_cycle(1'b0, took);
        endtask

        // Both sides idle for 8 rd_clk cycles, then levels match the model
        task automatic check_idle_levels();
                int n;
                repeat (8) @(posedge rd_clk);
                #2;
                n = model_q.size();
                assert (count == n)
                        else show_mismatch($sformatf("count %0d, expected %0d", count, n));
                assert (wr_flags.almost_full == (n >= AF_LEVEL))
                        else show_mismatch($sformatf("almost_full wrong at %0d words", n));
                assert (rd_flags.almost_empty == (n <= AE_LEVEL))
                        else show_mismatch($sformatf("almost_empty wrong at %0d words", n));
                assert (wr_flags.full == (n == DEPTH) && rd_flags.empty == (n == 0))
                        else show_mismatch($sformatf("full or empty wrong at %0d words", n));
        endtask

        // ------------------------------
        // Sequence
        // ------------------------------
        initial begin
                push     = 1'b0;
                pop      = 1'b0;
                wr_data  = '0;
                wr_rst_n = 1'b0;
                rd_rst_n = 1'b0;
                repeat (10) @(posedge rd_clk);
                #2;
                wr_rst_n = 1'b1;
                rd_rst_n = 1'b1;
                assert (wr_flags == '0 && rd_flags == 2'b11 && count == 0)
                        else show_mismatch("flags or count wrong after reset");
                check_idle_levels();
                // Writer faster than reader, reaches full
                fork
                        random_writes(300, 3);
                        random_reads(200, 2);
                join
                check_idle_levels();
                // Reader faster, runs into empty
                fork
                        random_writes(200, 1);
                        random_reads(250, 3);
                join
                check_idle_levels();
                drain_until_empty();
                check_idle_levels();
                fill_to_full();
                check_idle_levels();
                drain_until_empty();
                // Either side of the almost thresholds
                push_words(3);
                check_idle_levels();
                pop_words(1);
                check_idle_levels();
                push_words(12);
                check_idle_levels();
                pop_words(1);
                check_idle_levels();
                drain_until_empty();
                $display("Test OK");
                $finish;
        end

        // Watchdog
        initial begin
                for (int i = 0; i < RUN_LIMIT; i++) begin
                        @(posedge rd_clk);
                end
                waited_too_long("test did not finish within the cycle limit");
        end

endmodule

// ==== async_fifo.f ====
source/async_fifo_pkg.sv
source/fifo_ptr_counter.sv
source/fifo_ptr_sync.sv
source/fifo_mem.sv
source/fifo_control.sv
source/async_fifo.sv
tests/async_fifo_props.sv
tests/async_fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs both read modes, 0 is mux and 1 is flop
status=0
for mode in 0 1; do
        echo "Read mode $mode"
        verilator --binary --assert -Wno-fatal -f async_fifo.f \
                --top-module async_fifo_tb -GMODE=$mode -Mdir obj_dir_mode$mode \
                || { status=1; continue; }
        out=$(./obj_dir_mode$mode/Vasync_fifo_tb 2>&1)
        echo "$out"
        echo "$out" | grep -qx "Test OK" && echo "Mode $mode passed" || status=1
done
exit $status
